//--- design/ctrl_pkg.sv
// Shared bus widths, slave decode values, settings map and bus structs
// for the board control plane

package ctrl_pkg;

   ////////////////////////////////////////
   // Widths with a meaning

   typedef logic [31:0] wb_data_t;
   typedef logic [15:0] wb_addr_t;
   // Settings register address, byte address bits 9 to 2
   typedef logic [7:0]  set_addr_t;
   // Slave field, byte address bits 15 to 10
   typedef logic [5:0]  slave_sel_t;
   // Readback word, byte address bits 5 to 2
   typedef logic [3:0]  rb_index_t;
   typedef logic [7:0]  ctrl_byte_t;

   ////////////////////////////////////////
   // Slave decode and settings map

   localparam slave_sel_t SLAVE_SETTINGS = 6'b110101;
   localparam slave_sel_t SLAVE_READBACK = 6'b110011;

   localparam set_addr_t SR_CLOCK   = 8'd0;
   localparam set_addr_t SR_SERDES  = 8'd1;
   localparam set_addr_t SR_ADC     = 8'd2;
   localparam set_addr_t SR_LED_SW  = 8'd3;
   localparam set_addr_t SR_PHY     = 8'd4;
   localparam set_addr_t SR_ICACHE  = 8'd7;
   localparam set_addr_t SR_LED_SRC = 8'd8;

   ////////////////////////////////////////
   // Bus structs

   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     we;
      wb_addr_t adr;
      wb_data_t dat;
   } wb_req_t;

   typedef struct packed {
      logic     ack;
      logic     err;
      wb_data_t dat;
   } wb_rsp_t;

   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      wb_data_t  data;
   } set_bus_t;

   // Board control lines driven from the setting registers
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_resetn;
   } board_ctrl_t;

endpackage

//--- design/readback_mux.sv
// Status readback of 16 words with a free-running cycle counter
`timescale 1ns/1ps

module readback_mux #(
   parameter ctrl_pkg::wb_data_t COMPAT_NUM = 32'd3
) (
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  logic                 rb_req_i,
   input  ctrl_pkg::rb_index_t  rb_index_i,
   input  ctrl_pkg::ctrl_byte_t clock_byte_i,
   input  ctrl_pkg::ctrl_byte_t serdes_byte_i,
   input  ctrl_pkg::ctrl_byte_t adc_byte_i,
   input  logic                 sim_mode_i,
   input  logic [3:0]           clock_divider_i,
   input  logic [7:0]           irq_i,
   output ctrl_pkg::wb_data_t   rb_dat_o
);

   ctrl_pkg::wb_data_t cycle_count_q;
   ctrl_pkg::wb_data_t rb_word;
   ctrl_pkg::wb_data_t rb_dat_q;

   ////////////////////////////////////////
   // Cycle counter

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         cycle_count_q <= '0;
      end else begin
         cycle_count_q <= cycle_count_q + 32'd1;
      end
   end

   ////////////////////////////////////////
   // Word select

   always_comb begin
      case (rb_index_i)
         4'd0: begin
            rb_word = {24'd0, clock_byte_i};
         end
         4'd1: begin
            rb_word = {24'd0, serdes_byte_i};
         end
         4'd2: begin
            rb_word = {24'd0, adc_byte_i};
         end
         4'd3: begin
            // Sim mode flag on top, divider in the low nibble
            rb_word = {sim_mode_i, 27'd0, clock_divider_i};
         end
         4'd4: begin
            rb_word = COMPAT_NUM;
         end
         4'd5: begin
            rb_word = {24'd0, irq_i};
         end
         4'd6: begin
            rb_word = cycle_count_q;
         end
         default: begin
            rb_word = '0;
         end
      endcase
   end

   // Captured with the request, presented during ack
   always_ff @(posedge wb_clk) begin
      if (rb_req_i) begin
         rb_dat_q <= rb_word;
      end
   end

   assign rb_dat_o = rb_dat_q;

endmodule

//--- design/settings_regs.sv
// Board setting registers on the settings bus, the LED source mix
// and the instruction-cache flush pulse
`timescale 1ns/1ps

module settings_regs #(
   parameter ctrl_pkg::ctrl_byte_t LED_SRC_AT_RESET = 8'h1E
) (
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  ctrl_pkg::set_bus_t    set_bus_i,
   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   input  logic                  clk_status_i,
   input  logic                  serdes_link_up_i,
   output ctrl_pkg::board_ctrl_t board_ctrl_o,
   output ctrl_pkg::ctrl_byte_t  leds_o,
   output logic                  flush_icache_o,
   output ctrl_pkg::ctrl_byte_t  clock_byte_o,
   output ctrl_pkg::ctrl_byte_t  serdes_byte_o,
   output ctrl_pkg::ctrl_byte_t  adc_byte_o
);

   ctrl_pkg::ctrl_byte_t clock_q;
   ctrl_pkg::ctrl_byte_t serdes_q;
   ctrl_pkg::ctrl_byte_t adc_q;
   ctrl_pkg::ctrl_byte_t led_sw_q;
   ctrl_pkg::ctrl_byte_t led_src_q;
   ctrl_pkg::ctrl_byte_t led_hw;
   logic                 phy_rst_q;
   logic                 flush_q;

   // Strobe for one register address
   function automatic logic wr_hit(input ctrl_pkg::set_bus_t bus,
                                   input ctrl_pkg::set_addr_t addr);
      return bus.stb && (bus.addr == addr);
   endfunction

   ////////////////////////////////////////
   // Setting registers

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         clock_q   <= '0;
         serdes_q  <= '0;
         adc_q     <= '0;
         led_sw_q  <= '0;
         phy_rst_q <= 1'b0;
         led_src_q <= LED_SRC_AT_RESET;
         flush_q   <= 1'b0;
      end else begin
         if (wr_hit(set_bus_i, ctrl_pkg::SR_CLOCK)) begin
            clock_q <= set_bus_i.data[7:0];
         end
         if (wr_hit(set_bus_i, ctrl_pkg::SR_SERDES)) begin
            serdes_q <= set_bus_i.data[7:0];
         end
         if (wr_hit(set_bus_i, ctrl_pkg::SR_ADC)) begin
            adc_q <= set_bus_i.data[7:0];
         end
         if (wr_hit(set_bus_i, ctrl_pkg::SR_LED_SW)) begin
            led_sw_q <= set_bus_i.data[7:0];
         end
         if (wr_hit(set_bus_i, ctrl_pkg::SR_PHY)) begin
            phy_rst_q <= set_bus_i.data[0];
         end
         if (wr_hit(set_bus_i, ctrl_pkg::SR_LED_SRC)) begin
            led_src_q <= set_bus_i.data[7:0];
         end
         // Any write to the flush address fires, the data is ignored
         flush_q <= wr_hit(set_bus_i, ctrl_pkg::SR_ICACHE);
      end
   end

   ////////////////////////////////////////
   // LEDs, source bit 1 picks hardware

   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   ////////////////////////////////////////
   // Control line mapping

   always_comb begin
      board_ctrl_o.clock_ready = clock_q[4];
      board_ctrl_o.clk_en      = clock_q[3:2];
      board_ctrl_o.clk_sel     = clock_q[1:0];
      board_ctrl_o.ser_enable  = serdes_q[3];
      board_ctrl_o.ser_prbsen  = serdes_q[2];
      board_ctrl_o.ser_loopen  = serdes_q[1];
      board_ctrl_o.ser_rx_en   = serdes_q[0];
      board_ctrl_o.adc_oe_a    = adc_q[3];
      board_ctrl_o.adc_on_a    = adc_q[2];
      board_ctrl_o.adc_oe_b    = adc_q[1];
      board_ctrl_o.adc_on_b    = adc_q[0];
      // PHY register holds the reset, the pin is active low
      board_ctrl_o.phy_resetn  = ~phy_rst_q;
   end

   assign flush_icache_o = flush_q;
   assign clock_byte_o   = clock_q;
   assign serdes_byte_o  = serdes_q;
   assign adc_byte_o     = adc_q;

endmodule

//--- design/u2_ctrl_top.sv
// Board control plane top, Wishbone decode into the settings
// registers and the status readback mux
`timescale 1ns/1ps

module u2_ctrl_top #(
   parameter ctrl_pkg::wb_data_t   COMPAT_NUM       = 32'd3,
   parameter ctrl_pkg::ctrl_byte_t LED_SRC_AT_RESET = 8'h1E
) (
   input  logic                  wb_clk,
   input  logic                  wb_rst,

   // Processor bus
   input  ctrl_pkg::wb_req_t     wb_req_i,
   output ctrl_pkg::wb_rsp_t     wb_rsp_o,

   // Status inputs
   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   input  logic                  clk_status_i,
   input  logic                  serdes_link_up_i,
   input  logic                  sim_mode_i,
   input  logic [3:0]            clock_divider_i,
   input  logic [7:0]            irq_i,

   // Board controls
   output ctrl_pkg::board_ctrl_t board_ctrl_o,
   output ctrl_pkg::ctrl_byte_t  leds_o,
   output logic                  flush_icache_o
);

   ctrl_pkg::set_bus_t   set_bus;
   logic                 rb_req;
   ctrl_pkg::rb_index_t  rb_index;
   ctrl_pkg::wb_data_t   rb_dat;
   ctrl_pkg::ctrl_byte_t clock_byte;
   ctrl_pkg::ctrl_byte_t serdes_byte;
   ctrl_pkg::ctrl_byte_t adc_byte;

   ////////////////////////////////////////
   // Bus decode

   wb_slave_decode i_decode (
      .wb_clk     (wb_clk),
      .wb_rst     (wb_rst),
      .wb_req_i   (wb_req_i),
      .rb_dat_i   (rb_dat),
      .wb_rsp_o   (wb_rsp_o),
      .set_bus_o  (set_bus),
      .rb_req_o   (rb_req),
      .rb_index_o (rb_index)
   );

   ////////////////////////////////////////
   // Settings slave

   settings_regs #(
      .LED_SRC_AT_RESET (LED_SRC_AT_RESET)
   ) i_settings (
      .wb_clk           (wb_clk),
      .wb_rst           (wb_rst),
      .set_bus_i        (set_bus),
      .run_rx_i         (run_rx_i),
      .run_tx_i         (run_tx_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .board_ctrl_o     (board_ctrl_o),
      .leds_o           (leds_o),
      .flush_icache_o   (flush_icache_o),
      .clock_byte_o     (clock_byte),
      .serdes_byte_o    (serdes_byte),
      .adc_byte_o       (adc_byte)
   );

   ////////////////////////////////////////
   // Readback slave

   readback_mux #(
      .COMPAT_NUM (COMPAT_NUM)
   ) i_readback (
      .wb_clk          (wb_clk),
      .wb_rst          (wb_rst),
      .rb_req_i        (rb_req),
      .rb_index_i      (rb_index),
      .clock_byte_i    (clock_byte),
      .serdes_byte_i   (serdes_byte),
      .adc_byte_i      (adc_byte),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i),
      .irq_i           (irq_i),
      .rb_dat_o        (rb_dat)
   );

endmodule

//--- design/wb_slave_decode.sv
// Wishbone slave decode for the settings bus and the readback mux,
// answering every request with one registered ack or err
`timescale 1ns/1ps

module wb_slave_decode (
   input  logic                wb_clk,
   input  logic                wb_rst,
   input  ctrl_pkg::wb_req_t   wb_req_i,
   input  ctrl_pkg::wb_data_t  rb_dat_i,
   output ctrl_pkg::wb_rsp_t   wb_rsp_o,
   output ctrl_pkg::set_bus_t  set_bus_o,
   output logic                rb_req_o,
   output ctrl_pkg::rb_index_t rb_index_o
);

   ctrl_pkg::slave_sel_t slave_sel;
   logic                 hit_set;
   logic                 hit_rb;
   logic                 new_req;
   logic                 pending_q;
   logic                 ack_q;
   logic                 err_q;
   logic                 rb_rd_q;
   logic                 set_stb_q;
   ctrl_pkg::set_addr_t  set_addr_q;
   ctrl_pkg::wb_data_t   set_data_q;

   assign slave_sel = wb_req_i.adr[15:10];
   assign hit_set   = (slave_sel == ctrl_pkg::SLAVE_SETTINGS);
   assign hit_rb    = (slave_sel == ctrl_pkg::SLAVE_READBACK);

   // First cycle of a request only, the master holds stb until it sees the response
   assign new_req = wb_req_i.cyc & wb_req_i.stb & ~pending_q;

   // Mux registers the word at the same edge that raises ack
   assign rb_req_o   = new_req & hit_rb & ~wb_req_i.we;
   assign rb_index_o = wb_req_i.adr[5:2];

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         pending_q <= 1'b0;
         ack_q     <= 1'b0;
         err_q     <= 1'b0;
         rb_rd_q   <= 1'b0;
         set_stb_q <= 1'b0;
      end else begin
         pending_q <= wb_req_i.cyc & wb_req_i.stb;
         ack_q     <= new_req & (hit_set | hit_rb);
         err_q     <= new_req & ~(hit_set | hit_rb);
         rb_rd_q   <= rb_req_o;
         set_stb_q <= new_req & hit_set & wb_req_i.we;
      end
   end

   // Settings address and data, held for the strobe cycle
   always_ff @(posedge wb_clk) begin
      if (new_req && hit_set && wb_req_i.we) begin
         set_addr_q <= wb_req_i.adr[9:2];
         set_data_q <= wb_req_i.dat;
      end
   end

   always_comb begin
      wb_rsp_o.ack   = ack_q;
      wb_rsp_o.err   = err_q;
      // Settings reads and all writes return zero
      wb_rsp_o.dat   = rb_rd_q ? rb_dat_i : '0;
      set_bus_o.stb  = set_stb_q;
      set_bus_o.addr = set_addr_q;
      set_bus_o.data = set_data_q;
   end

endmodule

//--- dv/ctrl_checker.sv
// Board control plane checker, keeps a shadow of the settings writes and
// compares control outputs, LEDs, bus responses and readback words
`timescale 1ns/1ps

module ctrl_checker #(
   parameter ctrl_pkg::wb_data_t   COMPAT_NUM       = 32'd3,
   parameter ctrl_pkg::ctrl_byte_t LED_SRC_AT_RESET = 8'h1E
) (
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  ctrl_pkg::wb_req_t     wb_req_i,
   input  ctrl_pkg::wb_rsp_t     wb_rsp_i,
   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   input  logic                  clk_status_i,
   input  logic                  serdes_link_up_i,
   input  logic                  sim_mode_i,
   input  logic [3:0]            clock_divider_i,
   input  logic [7:0]            irq_i,
   input  ctrl_pkg::board_ctrl_t board_ctrl_i,
   input  ctrl_pkg::ctrl_byte_t  leds_i,
   input  logic                  flush_icache_i,
   input  int                    test_num_i,
   output int                    value_errs_o,
   output int                    protocol_errs_o
);

   // Shadow of the setting registers
   ctrl_pkg::ctrl_byte_t clock_s;
   ctrl_pkg::ctrl_byte_t serdes_s;
   ctrl_pkg::ctrl_byte_t adc_s;
   ctrl_pkg::ctrl_byte_t led_sw_s;
   ctrl_pkg::ctrl_byte_t led_src_s;
   logic                 phy_s;
   ctrl_pkg::wb_data_t   count_s;

   // Open request and what it should get back
   logic                 busy;
   logic                 resp_due;
   logic                 flush_due;
   logic                 exp_err;
   logic                 req_we;
   ctrl_pkg::wb_addr_t   req_adr;
   ctrl_pkg::wb_data_t   req_dat;
   ctrl_pkg::wb_data_t   exp_rdat;
   int                   value_errs = 0;
   int                   protocol_errs = 0;

   assign value_errs_o    = value_errs;
   assign protocol_errs_o = protocol_errs;

   function automatic string test_name(input int n);
      case (n)
         1: return "reset_state";
         2: return "settings_write";
         3: return "led_mix";
         4: return "readback";
         5: return "bus_response";
         6: return "cache_flush";
         default: return "setup";
      endcase
   endfunction

   ////////////////////////////////////////
   // Reference model

   // Clock, serdes and ADC fields stack in the same order as the struct
   function automatic ctrl_pkg::board_ctrl_t expected_ctrl();
      return {clock_s[4:0], serdes_s[3:0], adc_s[3:0], ~phy_s};
   endfunction

   function automatic ctrl_pkg::ctrl_byte_t expected_leds();
      ctrl_pkg::ctrl_byte_t hw;
      ctrl_pkg::ctrl_byte_t mix;
      int                   b;
      hw    = 8'h00;
      hw[4] = run_tx_i;
      hw[3] = run_rx_i;
      hw[2] = clk_status_i;
      hw[1] = serdes_link_up_i;
      for (b = 0; b < 8; b++) begin
         mix[b] = led_src_s[b] ? hw[b] : led_sw_s[b];
      end
      return mix;
   endfunction

   function automatic ctrl_pkg::wb_data_t expected_word(input ctrl_pkg::rb_index_t idx);
      case (idx)
         4'd0: return {24'd0, clock_s};
         4'd1: return {24'd0, serdes_s};
         4'd2: return {24'd0, adc_s};
         4'd3: return {sim_mode_i, 27'd0, clock_divider_i};
         4'd4: return COMPAT_NUM;
         4'd5: return {24'd0, irq_i};
         4'd6: return count_s;
         default: return 32'd0;
      endcase
   endfunction

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      if (act !== exp) begin
         $display("Fail %s %s: expected 0x%08h, actual 0x%08h",
                  test_name(test_num_i), what, exp, act);
         value_errs++;
      end
   endtask

   task automatic report_protocol(input string msg);
      $display("Error in %s: %s", test_name(test_num_i), msg);
      protocol_errs++;
   endtask

   task automatic apply_write();
      case (req_adr[9:2])
         ctrl_pkg::SR_CLOCK:   clock_s   = req_dat[7:0];
         ctrl_pkg::SR_SERDES:  serdes_s  = req_dat[7:0];
         ctrl_pkg::SR_ADC:     adc_s     = req_dat[7:0];
         ctrl_pkg::SR_LED_SW:  led_sw_s  = req_dat[7:0];
         ctrl_pkg::SR_PHY:     phy_s     = req_dat[0];
         ctrl_pkg::SR_LED_SRC: led_src_s = req_dat[7:0];
         ctrl_pkg::SR_ICACHE:  flush_due = 1'b1;
         default: ;
      endcase
   endtask

   ////////////////////////////////////////
   // Compare on every rising edge, values of the cycle just ended

   always @(posedge wb_clk) begin
      if (wb_rst) begin
         clock_s   = '0;
         serdes_s  = '0;
         adc_s     = '0;
         led_sw_s  = '0;
         phy_s     = 1'b0;
         led_src_s = LED_SRC_AT_RESET;
         count_s   = '0;
         busy      = 1'b0;
         resp_due  = 1'b0;
         flush_due = 1'b0;
      end else begin
         check_value("board_ctrl", expected_ctrl(), board_ctrl_i);
         check_value("leds", expected_leds(), leds_i);
         if (flush_icache_i !== flush_due) begin
            if (flush_due) begin
               report_protocol("no flush pulse after a write to address 7");
            end else begin
               report_protocol("flush pulse without a write to address 7");
            end
         end
         flush_due = 1'b0;

         if (resp_due) begin
            if (exp_err && (wb_rsp_i.err !== 1'b1 || wb_rsp_i.ack !== 1'b0)) begin
               report_protocol("no err one cycle after a request outside both slaves");
            end else if (!exp_err && (wb_rsp_i.ack !== 1'b1 || wb_rsp_i.err !== 1'b0)) begin
               report_protocol("no ack one cycle after a request to a slave");
            end else if (!exp_err && !req_we) begin
               check_value("read_data", exp_rdat, wb_rsp_i.dat);
            end
            if (!exp_err && req_we && req_adr[15:10] == ctrl_pkg::SLAVE_SETTINGS) begin
               apply_write();
            end
         end else if (wb_rsp_i.ack !== 1'b0 || wb_rsp_i.err !== 1'b0) begin
            report_protocol("ack or err with no open request, doubled or unexpected");
         end
         resp_due = 1'b0;

         // A request starts when cyc and stb rise with nothing open
         if (wb_req_i.cyc && wb_req_i.stb && !busy) begin
            resp_due = 1'b1;
            req_we   = wb_req_i.we;
            req_adr  = wb_req_i.adr;
            req_dat  = wb_req_i.dat;
            exp_err  = !(wb_req_i.adr[15:10] == ctrl_pkg::SLAVE_SETTINGS ||
                         wb_req_i.adr[15:10] == ctrl_pkg::SLAVE_READBACK);
            if (wb_req_i.adr[15:10] == ctrl_pkg::SLAVE_READBACK) begin
               exp_rdat = expected_word(wb_req_i.adr[5:2]);
            end else begin
               exp_rdat = '0;
            end
         end
         busy    = wb_req_i.cyc && wb_req_i.stb;
         count_s = count_s + 32'd1;
      end
   end

endmodule

//--- dv/tb_top.sv
// Testbench for the board control plane, with clock, reset, a Wishbone
// master and the stimulus for all tests
`timescale 1ns/1ps

module tb_top;

   localparam ctrl_pkg::wb_data_t   COMPAT_NUM       = 32'd3;
   localparam ctrl_pkg::ctrl_byte_t LED_SRC_AT_RESET = 8'h1E;
   // Stimulus runs well under 1000 cycles
   localparam int TIMEOUT_CYCLES = 2000;

   logic                  wb_clk;
   logic                  wb_rst;
   ctrl_pkg::wb_req_t     wb_req;
   ctrl_pkg::wb_rsp_t     wb_rsp;
   logic                  run_rx;
   logic                  run_tx;
   logic                  clk_status;
   logic                  serdes_link_up;
   logic                  sim_mode;
   logic [3:0]            clock_divider;
   logic [7:0]            irq;
   ctrl_pkg::board_ctrl_t board_ctrl;
   ctrl_pkg::ctrl_byte_t  leds;
   logic                  flush_icache;
   int                    test_num;
   int                    value_errs;
   int                    protocol_errs;
   int                    cycles = 0;

   u2_ctrl_top #(
      .COMPAT_NUM       (COMPAT_NUM),
      .LED_SRC_AT_RESET (LED_SRC_AT_RESET)
   ) i_dut (
      .wb_clk           (wb_clk),
      .wb_rst           (wb_rst),
      .wb_req_i         (wb_req),
      .wb_rsp_o         (wb_rsp),
      .run_rx_i         (run_rx),
      .run_tx_i         (run_tx),
      .clk_status_i     (clk_status),
      .serdes_link_up_i (serdes_link_up),
      .sim_mode_i       (sim_mode),
      .clock_divider_i  (clock_divider),
      .irq_i            (irq),
      .board_ctrl_o     (board_ctrl),
      .leds_o           (leds),
      .flush_icache_o   (flush_icache)
   );

   ctrl_checker #(
      .COMPAT_NUM       (COMPAT_NUM),
      .LED_SRC_AT_RESET (LED_SRC_AT_RESET)
   ) i_chk (
      .wb_clk           (wb_clk),
      .wb_rst           (wb_rst),
      .wb_req_i         (wb_req),
      .wb_rsp_i         (wb_rsp),
      .run_rx_i         (run_rx),
      .run_tx_i         (run_tx),
      .clk_status_i     (clk_status),
      .serdes_link_up_i (serdes_link_up),
      .sim_mode_i       (sim_mode),
      .clock_divider_i  (clock_divider),
      .irq_i            (irq),
      .board_ctrl_i     (board_ctrl),
      .leds_i           (leds),
      .flush_icache_i   (flush_icache),
      .test_num_i       (test_num),
      .value_errs_o     (value_errs),
      .protocol_errs_o  (protocol_errs)
   );

   initial begin
      wb_clk = 1'b0;
      forever #2 wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk) begin
      cycles = cycles + 1;
      if (cycles > TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Errors: value %0d, protocol %0d", value_errs, protocol_errs);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Bus master and stimulus helpers

   task automatic randomize_status();
      int unsigned r;
      r              = $urandom;
      run_rx         = r[0];
      run_tx         = r[1];
      clk_status     = r[2];
      serdes_link_up = r[3];
      sim_mode       = r[4];
      clock_divider  = r[11:8];
      irq            = r[23:16];
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge wb_clk);
         randomize_status();
      end
   endtask

   // Holds the request until ack or err, then drops stb
   task automatic bus_access(input logic we, input ctrl_pkg::wb_addr_t adr,
                             input ctrl_pkg::wb_data_t dat);
      @(negedge wb_clk);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = dat;
      @(negedge wb_clk);
      while (wb_rsp.ack !== 1'b1 && wb_rsp.err !== 1'b1) begin
         @(negedge wb_clk);
      end
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
   endtask

   function automatic ctrl_pkg::wb_addr_t settings_adr(input ctrl_pkg::set_addr_t a);
      return {ctrl_pkg::SLAVE_SETTINGS, a, 2'b00};
   endfunction

   function automatic ctrl_pkg::wb_addr_t readback_adr(input ctrl_pkg::rb_index_t i);
      return {ctrl_pkg::SLAVE_READBACK, 4'b0000, i, 2'b00};
   endfunction

   // Mostly mapped registers, sometimes an unused address
   task automatic write_random_setting();
      int unsigned          pick;
      ctrl_pkg::set_addr_t  a;
      pick = $urandom_range(7, 0);
      if (pick == 5) begin
         a = ctrl_pkg::SR_LED_SRC;
      end else if (pick < 5) begin
         a = ctrl_pkg::set_addr_t'(pick);
      end else if (pick == 6) begin
         a = ctrl_pkg::set_addr_t'($urandom_range(6, 5));
      end else begin
         a = ctrl_pkg::set_addr_t'($urandom_range(255, 9));
      end
      bus_access(1'b1, settings_adr(a), $urandom);
   endtask

   task automatic access_outside();
      ctrl_pkg::slave_sel_t sel;
      int unsigned          r;
      sel = ctrl_pkg::slave_sel_t'($urandom_range(63, 0));
      while (sel == ctrl_pkg::SLAVE_SETTINGS || sel == ctrl_pkg::SLAVE_READBACK) begin
         sel = ctrl_pkg::slave_sel_t'($urandom_range(63, 0));
      end
      r = $urandom;
      bus_access(r[31], {sel, r[9:0]}, $urandom);
   endtask

   ////////////////////////////////////////
   // Stimulus

   initial begin
      void'($urandom(70));
      wb_rst   = 1'b1;
      wb_req   = '0;
      test_num = 0;
      randomize_status();
      repeat (16) @(posedge wb_clk);
      @(negedge wb_clk);
      wb_rst = 1'b0;

      test_num = 1;
      idle(8);

      test_num = 2;
      repeat (40) write_random_setting();
      idle(3);

      test_num = 3;
      repeat (20) begin
         bus_access(1'b1, settings_adr(ctrl_pkg::SR_LED_SRC), $urandom);
         bus_access(1'b1, settings_adr(ctrl_pkg::SR_LED_SW), $urandom);
         idle(2);
      end

      test_num = 4;
      for (int i = 0; i < 16; i++) begin
         bus_access(1'b0, readback_adr(ctrl_pkg::rb_index_t'(i)), 32'd0);
         idle(1);
      end
      bus_access(1'b0, readback_adr(4'd6), 32'd0);
      // Readback word still holds the count here
      bus_access(1'b0, settings_adr(ctrl_pkg::SR_CLOCK), 32'd0);
      idle($urandom_range(20, 1));
      bus_access(1'b0, readback_adr(4'd6), 32'd0);

      test_num = 5;
      repeat (20) access_outside();
      bus_access(1'b1, readback_adr(4'd0), $urandom);
      idle(2);

      test_num = 6;
      repeat (6) begin
         bus_access(1'b1, settings_adr(ctrl_pkg::SR_ICACHE), $urandom);
         write_random_setting();
         idle(2);
      end
      bus_access(1'b1, settings_adr(ctrl_pkg::SR_ICACHE), $urandom);
      bus_access(1'b1, settings_adr(ctrl_pkg::SR_ICACHE), $urandom);
      idle(4);

      $display("Errors: value %0d, protocol %0d", value_errs, protocol_errs);
      if (value_errs == 0 && protocol_errs == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- verilog.f
design/ctrl_pkg.sv
design/wb_slave_decode.sv
design/settings_regs.sv
design/readback_mux.sv
design/u2_ctrl_top.sv
dv/ctrl_checker.sv
dv/tb_top.sv
